// ==== Makefile ====
# Verilator build for the branch execute slice

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_branch_exec
FILELIST  := branch_exec_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := TEST RESULT: FAIL
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides, the simulator exit status is not trusted
run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== branch_exec_top.f ====
source/bru_pkg.sv
source/exec_pipe_reg.sv
source/branch_compare.sv
source/branch_unit.sv
source/branch_exec_top.sv
tb/branch_exec_chk.sv
tb/tb_branch_exec.sv

// ==== source/branch_compare.sv ====
/*
 * Branch compare
 * Evaluates the branch condition for the six compare operations and
 * reports unconditional jumps as taken.
 */

`timescale 1ns/1ps
`default_nettype none

module branch_compare import bru_pkg::*; (
    input  fu_op_e            op_i,
    input  logic [XLEN-1:0]   operand_a_i,
    input  logic [XLEN-1:0]   operand_b_i,
    output logic              taken_o
);

    logic is_equal;
    logic less_signed;
    logic less_unsigned;

    // Shared relations, each compare op picks one and maybe inverts it
    assign is_equal      = (operand_a_i == operand_b_i);
    assign less_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
    assign less_unsigned = (operand_a_i < operand_b_i);

    always_comb begin
        if (!op_is_branch(op_i)) begin
            // JAL and JALR always redirect
            taken_o = (op_i == JAL) || (op_i == JALR);
        end else begin
            case (op_i)
                BEQ:     taken_o = is_equal;
                BNE:     taken_o = !is_equal;
                BLT:     taken_o = less_signed;
                BGE:     taken_o = !less_signed;
                BLTU:    taken_o = less_unsigned;
                BGEU:    taken_o = !less_unsigned;
                default: taken_o = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/branch_exec_top.sv ====
/*
 * Branch execute slice
 * Issue stage register, branch compare, branch unit and result stage
 * register. A valid mispredict on the output flushes both stages.
 */

`timescale 1ns/1ps
`default_nettype none

module branch_exec_top import bru_pkg::*; #(
    parameter bit RVC = 1'b1
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             issue_valid_i,
    input  issue_t           issue_i,
    output logic             result_valid_o,
    output logic [XLEN-1:0]  link_o,
    output bp_resolve_t      resolved_o,
    output exception_t       exception_o
);

    logic          stage_valid;
    issue_t        stage_issue;
    logic          comp_taken;
    exec_result_t  result_d;
    exec_result_t  result_q;
    logic          flush;

    // Kill wrong-path work in both stages
    assign flush = result_valid_o && result_q.resolved.is_mispredict;

    exec_pipe_reg #(.payload_t(issue_t)) i_issue_stage (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush),
        .valid_i (issue_valid_i),
        .data_i  (issue_i),
        .valid_o (stage_valid),
        .data_o  (stage_issue)
    );

    branch_compare i_branch_compare (
        .op_i        (stage_issue.fu_data.operation),
        .operand_a_i (stage_issue.fu_data.operand_a),
        .operand_b_i (stage_issue.fu_data.operand_b),
        .taken_o     (comp_taken)
    );

    branch_unit #(.RVC(RVC)) i_branch_unit (
        .valid_i      (stage_valid),
        .issue_i      (stage_issue),
        .comp_taken_i (comp_taken),
        .result_o     (result_d)
    );

    exec_pipe_reg #(.payload_t(exec_result_t)) i_result_stage (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush),
        .valid_i (result_d.resolved.valid),
        .data_i  (result_d),
        .valid_o (result_valid_o),
        .data_o  (result_q)
    );

    assign link_o = result_q.link;

    // Flushed payloads must not leak valid flags
    always_comb begin
        resolved_o             = result_q.resolved;
        resolved_o.valid       = result_valid_o;
        exception_o            = result_q.exception;
        exception_o.valid      = result_q.exception.valid && result_valid_o;
    end

endmodule

`default_nettype wire

// ==== source/branch_unit.sv ====
/*
 * Branch unit
 * Computes the link value and jump target, builds the resolution record
 * with the misprediction decision, and raises the instruction address
 * misaligned exception when compressed instructions are not supported.
 */

`timescale 1ns/1ps
`default_nettype none

module branch_unit import bru_pkg::*; #(
    parameter bit RVC = 1'b1
) (
    input  logic          valid_i,
    input  issue_t        issue_i,
    input  logic          comp_taken_i,
    output exec_result_t  result_o
);

    logic [XLEN-1:0] pc_step;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] jump_base;
    logic [XLEN-1:0] target_address;
    logic            is_branch;
    logic            is_jalr;
    logic            jump_taken;

    assign is_branch = op_is_branch(issue_i.fu_data.operation);
    assign is_jalr   = (issue_i.fu_data.operation == JALR);

    // Fall-through address, also the link written to rd
    assign pc_step = issue_i.is_compressed ? XLEN'(2) : XLEN'(4);
    assign next_pc = issue_i.pc + pc_step;

    // JALR jumps relative to rs1, all others relative to the PC
    assign jump_base = is_jalr ? issue_i.fu_data.operand_a : issue_i.pc;

    always_comb begin
        target_address = jump_base + issue_i.fu_data.imm;
        // JALR drops the lowest target bit
        if (is_jalr) begin
            target_address[0] = 1'b0;
        end
    end

    // Taken means a taken compare or any jump
    assign jump_taken = comp_taken_i;

    always_comb begin
        result_o.link = next_pc;

        // Defaults, the predicted type passes through for JAL
        result_o.resolved.valid          = valid_i;
        result_o.resolved.pc             = issue_i.pc;
        result_o.resolved.target_address = '0;
        result_o.resolved.is_mispredict  = 1'b0;
        result_o.resolved.is_taken       = 1'b0;
        result_o.resolved.cf_type        = issue_i.predict.cf;

        if (valid_i) begin
            // Not taken falls back to the next sequential PC
            result_o.resolved.target_address = jump_taken ? target_address : next_pc;
            result_o.resolved.is_taken       = jump_taken;

            if (is_branch) begin
                // BHT update, wrong when outcome and predicted direction disagree
                result_o.resolved.cf_type       = BRANCH;
                result_o.resolved.is_mispredict =
                    comp_taken_i != (issue_i.predict.cf == BRANCH);
            end

            // Register jump, no prediction or wrong address
            if (is_jalr &&
                (issue_i.predict.cf == NO_CF ||
                 target_address != issue_i.predict.predict_address)) begin
                result_o.resolved.is_mispredict = 1'b1;
                // Returns keep their class so the RAS is not confused with the BTB
                if (issue_i.predict.cf != RETURN) begin
                    result_o.resolved.cf_type = JUMP_R;
                end
            end
        end
    end

    always_comb begin
        result_o.exception.cause = EXC_INSTR_ADDR_MISALIGNED;
        result_o.exception.tval  = issue_i.pc;
        result_o.exception.valid = 1'b0;
        // Without RVC every fetch target must be word aligned
        if (!RVC) begin
            if (valid_i && jump_taken && (target_address[1:0] != 2'b00)) begin
                result_o.exception.valid = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/bru_pkg.sv ====
/*
 * Branch resolution package
 * Shared width, operation and control-flow encodings, and the packed
 * structs passed between the issue port, the branch unit and the
 * result stage of the execute slice.
 */

`default_nettype none

package bru_pkg;

    // Data and address width
    localparam int unsigned XLEN = 32;

    // Control-flow operations handled by this slice
    typedef enum logic [3:0] {
        BEQ  = 4'd0,
        BNE  = 4'd1,
        BLT  = 4'd2,
        BGE  = 4'd3,
        BLTU = 4'd4,
        BGEU = 4'd5,
        JAL  = 4'd6,
        JALR = 4'd7
    } fu_op_e;

    // Control-flow class as seen by the predictor
    typedef enum logic [2:0] {
        NO_CF  = 3'd0,
        BRANCH = 3'd1,
        JUMP   = 3'd2,
        JUMP_R = 3'd3,
        RETURN = 3'd4
    } cf_e;

    // Exception cause code for a misaligned fetch target
    localparam logic [3:0] EXC_INSTR_ADDR_MISALIGNED = 4'd0;

    typedef struct packed {
        fu_op_e            operation;
        logic [XLEN-1:0]   operand_a;
        logic [XLEN-1:0]   operand_b;
        logic [XLEN-1:0]   imm;
    } fu_data_t;

    // What the front end guessed at fetch time
    typedef struct packed {
        cf_e               cf;
        logic [XLEN-1:0]   predict_address;
    } branch_predict_t;

    // Payload of the input stage
    typedef struct packed {
        fu_data_t          fu_data;
        logic [XLEN-1:0]   pc;
        logic              is_compressed;
        branch_predict_t   predict;
    } issue_t;

    // Resolution record sent back towards the predictor
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   target_address;
        logic              is_mispredict;
        logic              is_taken;
        cf_e               cf_type;
    } bp_resolve_t;

    typedef struct packed {
        logic [3:0]        cause;
        logic [XLEN-1:0]   tval;
        logic              valid;
    } exception_t;

    // Payload of the output stage
    typedef struct packed {
        logic [XLEN-1:0]   link;
        bp_resolve_t       resolved;
        exception_t        exception;
    } exec_result_t;

    // True for the six conditional compare operations
    function automatic logic op_is_branch(input fu_op_e op);
        case (op)
            BEQ, BNE, BLT, BGE, BLTU, BGEU: return 1'b1;
            default:                        return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== source/exec_pipe_reg.sv ====
/*
 * Execute pipeline register
 * Valid-tagged stage register with synchronous flush, shared by the
 * issue and result stages through a type parameter.
 */

`timescale 1ns/1ps
`default_nettype none

module exec_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      valid_i,
    input  payload_t  data_i,
    output logic      valid_o,
    output payload_t  data_o
);

    logic     valid_q;
    payload_t data_q;

    // Valid tag, cleared by reset or flush
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // Payload loads every cycle, only meaningful with valid_q
    always_ff @(posedge clk_i) begin
        data_q <= data_i;
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

`default_nettype wire

// ==== tb/branch_exec_chk.sv ====
/*
 * Branch execute slice checker
 * Concurrent assertions on the result port, bound into the top level.
 */

`timescale 1ns/1ps
`default_nettype none

module branch_exec_chk import bru_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         result_valid_i,
    input  bp_resolve_t  resolved_i,
    input  exception_t   exception_i
);

    // Nothing comes out right after reset
    assert property (@(posedge clk_i) $rose(rst_n_i) |=> !result_valid_i)
        else $error("result valid in the cycle after reset release");

    // A misaligned target only exists on a valid taken result
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exception_i.valid |-> (result_valid_i && resolved_i.is_taken))
        else $error("exception without a valid taken result");

    // Mispredict flushes whatever follows it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (result_valid_i && resolved_i.is_mispredict) |=> !result_valid_i)
        else $error("valid result right after a mispredict");

endmodule

bind branch_exec_top branch_exec_chk i_chk (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .result_valid_i (result_valid_o),
    .resolved_i     (resolved_o),
    .exception_i    (exception_o)
);

`default_nettype wire

// ==== tb/tb_branch_exec.sv ====
/*
 * Testbench for the branch execute slice
 * Runs a table of control-flow issues and then random spaced branches,
 * predicts each result with a reference model, and checks values,
 * output timing and the flush of wrong-path issues.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_branch_exec import bru_pkg::*; ();

    localparam int unsigned NUM_STIM    = 23;
    localparam int unsigned NUM_RAND    = 40;
    localparam int unsigned CYCLE_LIMIT = NUM_STIM * 4 + NUM_RAND * 4 + 50;

    // One table row, the issue plus idle cycles after it
    typedef struct packed {
        issue_t       issue;
        int unsigned  gap;
    } stim_t;

    // Expected result and the cycle it is due in
    typedef struct packed {
        exec_result_t  res;
        logic          dropped;
        int unsigned   out_cycle;
    } expect_t;

    logic             clk;
    logic             rst_n;
    logic             issue_valid;
    issue_t           issue;
    logic             result_valid;
    logic [XLEN-1:0]  link;
    bp_resolve_t      resolved;
    exception_t       exception;

    stim_t            table_mem [NUM_STIM];
    expect_t          exp_q [$];
    expect_t          cur;
    int unsigned      cycle_cnt = 0;
    int unsigned      errors = 0;
    int unsigned      checks = 0;
    int unsigned      missing = 0;
    bit               mp_seen = 1'b0;
    int unsigned      mp_edge = 0;
    int unsigned      seed;

    // RVC off so misaligned targets raise the exception
    branch_exec_top #(.RVC(1'b0)) DUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .issue_valid_i  (issue_valid),
        .issue_i        (issue),
        .result_valid_o (result_valid),
        .link_o         (link),
        .resolved_o     (resolved),
        .exception_o    (exception)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Edge count, after edge n it reads n
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic stim_t make_row(input fu_op_e op, input logic [XLEN-1:0] a,
                                       input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm,
                                       input logic [XLEN-1:0] pc, input logic comp,
                                       input cf_e pcf, input logic [XLEN-1:0] paddr,
                                       input int unsigned gap);
        stim_t s;
        s = '0;
        s.issue.fu_data.operation     = op;
        s.issue.fu_data.operand_a     = a;
        s.issue.fu_data.operand_b     = b;
        s.issue.fu_data.imm           = imm;
        s.issue.pc                    = pc;
        s.issue.is_compressed         = comp;
        s.issue.predict.cf            = pcf;
        s.issue.predict.predict_address = paddr;
        s.gap                         = gap;
        return s;
    endfunction

    task automatic load_table();
        // Compare ops with signed and unsigned edge operands
        table_mem[0]  = make_row(BEQ, 32'h5, 32'h5, 32'h10, 32'h100, 1'b0, BRANCH, 32'h0, 3);
        table_mem[1]  = make_row(BNE, 32'h5, 32'h5, 32'h10, 32'h110, 1'b1, NO_CF, 32'h0, 3);
        table_mem[2]  = make_row(BLT, 32'h80000000, 32'h1, 32'hfffffff8, 32'h120, 1'b0,
                                 BRANCH, 32'h0, 3);
        table_mem[3]  = make_row(BLTU, 32'h80000000, 32'h1, 32'hfffffff8, 32'h130, 1'b0,
                                 BRANCH, 32'h0, 3);
        table_mem[4]  = make_row(BGE, 32'hffffffff, 32'h0, 32'h20, 32'h140, 1'b0, NO_CF, 32'h0, 3);
        table_mem[5]  = make_row(BGEU, 32'hffffffff, 32'h0, 32'h20, 32'h150, 1'b0, NO_CF, 32'h0, 3);
        table_mem[6]  = make_row(BGE, 32'h7, 32'h7, 32'h8, 32'h160, 1'b0, BRANCH, 32'h0, 3);
        table_mem[7]  = make_row(BLTU, 32'h3, 32'h3, 32'h8, 32'h170, 1'b0, NO_CF, 32'h0, 3);
        // Misaligned target, not taken then taken
        table_mem[8]  = make_row(BEQ, 32'h1, 32'h2, 32'h6, 32'h180, 1'b0, BRANCH, 32'h0, 3);
        table_mem[9]  = make_row(BNE, 32'h1, 32'h2, 32'h6, 32'h190, 1'b0, BRANCH, 32'h0, 3);
        // Jumps
        table_mem[10] = make_row(JAL, 32'h0, 32'h0, 32'h40, 32'h200, 1'b0, JUMP, 32'h240, 3);
        table_mem[11] = make_row(JAL, 32'h0, 32'h0, 32'h40, 32'h210, 1'b0, NO_CF, 32'h0, 3);
        table_mem[12] = make_row(JALR, 32'h301, 32'h0, 32'h10, 32'h220, 1'b0, JUMP_R, 32'h310, 3);
        table_mem[13] = make_row(JALR, 32'h301, 32'h0, 32'h0, 32'h230, 1'b0, NO_CF, 32'h0, 3);
        table_mem[14] = make_row(JALR, 32'h400, 32'h0, 32'h4, 32'h240, 1'b0, RETURN, 32'h500, 3);
        table_mem[15] = make_row(JALR, 32'h403, 32'h0, 32'h0, 32'h250, 1'b0, JUMP_R, 32'h402, 3);
        // Back-to-back, all predicted right
        table_mem[16] = make_row(BEQ, 32'h1, 32'h1, 32'h10, 32'h300, 1'b0, BRANCH, 32'h0, 0);
        table_mem[17] = make_row(BNE, 32'h1, 32'h2, 32'h10, 32'h304, 1'b0, BRANCH, 32'h0, 0);
        table_mem[18] = make_row(BLT, 32'h1, 32'h2, 32'h10, 32'h308, 1'b0, BRANCH, 32'h0, 3);
        // Mispredict, the next two issues are wrong path
        table_mem[19] = make_row(BEQ, 32'h1, 32'h2, 32'h10, 32'h400, 1'b0, BRANCH, 32'h0, 0);
        table_mem[20] = make_row(BEQ, 32'h1, 32'h1, 32'h10, 32'h404, 1'b0, BRANCH, 32'h0, 0);
        table_mem[21] = make_row(JAL, 32'h0, 32'h0, 32'h20, 32'h408, 1'b0, JUMP, 32'h0, 0);
        table_mem[22] = make_row(BNE, 32'h1, 32'h2, 32'h10, 32'h40c, 1'b0, BRANCH, 32'h0, 3);
    endtask

    // Reference model, written for RVC off
    function automatic exec_result_t predict_result(input issue_t is);
        exec_result_t     r;
        logic             taken;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [XLEN-1:0]  nxt;
        logic [XLEN-1:0]  tgt;
        a   = is.fu_data.operand_a;
        b   = is.fu_data.operand_b;
        nxt = is.pc + (is.is_compressed ? 32'd2 : 32'd4);
        case (is.fu_data.operation)
            BEQ:     taken = (a == b);
            BNE:     taken = (a != b);
            BLT:     taken = ($signed(a) < $signed(b));
            BGE:     taken = ($signed(a) >= $signed(b));
            BLTU:    taken = (a < b);
            BGEU:    taken = (a >= b);
            default: taken = 1'b1;
        endcase
        if (is.fu_data.operation == JALR) begin
            tgt = (a + is.fu_data.imm) & ~32'h1;
        end else begin
            tgt = is.pc + is.fu_data.imm;
        end
        r = '0;
        r.link                    = nxt;
        r.resolved.valid          = 1'b1;
        r.resolved.pc             = is.pc;
        r.resolved.target_address = taken ? tgt : nxt;
        r.resolved.is_taken       = taken;
        case (is.fu_data.operation)
            JAL: begin
                r.resolved.cf_type       = is.predict.cf;
                r.resolved.is_mispredict = 1'b0;
            end
            JALR: begin
                r.resolved.cf_type       = (is.predict.cf == RETURN) ? RETURN : JUMP_R;
                r.resolved.is_mispredict = (is.predict.cf == NO_CF) ||
                                           (is.predict.predict_address != tgt);
            end
            default: begin
                r.resolved.cf_type       = BRANCH;
                r.resolved.is_mispredict = taken != (is.predict.cf == BRANCH);
            end
        endcase
        r.exception.cause = EXC_INSTR_ADDR_MISALIGNED;
        r.exception.tval  = is.pc;
        r.exception.valid = taken && (tgt[1:0] != 2'b00);
        return r;
    endfunction

    // Drive one issue, queue its expected result, then idle for gap cycles
    task automatic issue_one(input issue_t is, input int unsigned gap);
        expect_t      e;
        int unsigned  edge_no;
        @(posedge clk);
        #1;
        issue_valid = 1'b1;
        issue       = is;
        edge_no     = cycle_cnt + 1;
        e.res       = predict_result(is);
        e.out_cycle = edge_no + 1;
        // Wrong path if sampled one or two edges after a surviving mispredict
        e.dropped   = mp_seen && (edge_no - mp_edge <= 2);
        if (!e.dropped && e.res.resolved.is_mispredict) begin
            mp_seen = 1'b1;
            mp_edge = edge_no;
        end
        exp_q.push_back(e);
        repeat (gap) begin
            @(posedge clk);
            #1;
            issue_valid = 1'b0;
        end
    endtask

    task automatic run_random();
        issue_t           is;
        logic [XLEN-1:0]  a;
        repeat (NUM_RAND) begin
            is                   = '0;
            a                    = $urandom;
            is.fu_data.operation = fu_op_e'(4'($urandom_range(0, 5)));
            is.fu_data.operand_a = a;
            // Equal operands now and then
            is.fu_data.operand_b = ($urandom_range(0, 3) == 0) ? a : $urandom;
            is.fu_data.imm       = (32'($urandom_range(0, 63)) << 1) - 32'd64;
            is.pc                = 32'($urandom_range(256, 4095)) << 2;
            is.predict.cf        = ($urandom_range(0, 1) == 1) ? BRANCH : NO_CF;
            issue_one(is, 3);
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (result_valid) begin
            while (exp_q.size() > 0 && exp_q[0].dropped) begin
                cur = exp_q.pop_front();
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR: a result came out at %0t with no issue outstanding", $time);
            end else begin
                cur = exp_q.pop_front();
                checks++;
                assert (cycle_cnt == cur.out_cycle) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: pc 0x%h out in cycle %0d, expected %0d",
                             $time, cur.res.resolved.pc, cycle_cnt, cur.out_cycle);
                end
                assert (link == cur.res.link) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: link 0x%h, expected 0x%h",
                             $time, link, cur.res.link);
                end
                assert (resolved == cur.res.resolved) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: resolved 0x%h, expected 0x%h",
                             $time, resolved, cur.res.resolved);
                end
                assert (exception.valid == cur.res.exception.valid) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: pc 0x%h exception valid %b, expected %b",
                             $time, resolved.pc, exception.valid, cur.res.exception.valid);
                end
                if (cur.res.exception.valid) begin
                    assert (exception.cause == cur.res.exception.cause &&
                            exception.tval == cur.res.exception.tval) else begin
                        errors++;
                        $display("CHECK FAILED at %0t: exception cause %0d tval 0x%h",
                                 $time, exception.cause, exception.tval);
                    end
                end
            end
        end
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
        end
        $display("ERROR: timeout after %0d cycles, the run did not finish", cycle_cnt);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        seed        = $urandom(32'hfcf6);
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        load_table();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < NUM_STIM; i++) begin
            issue_one(table_mem[i].issue, table_mem[i].gap);
        end
        run_random();
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        foreach (exp_q[i]) begin
            if (!exp_q[i].dropped) begin
                missing++;
            end
        end
        if (missing != 0) begin
            errors += missing;
            $display("ERROR: %0d expected results never came out", missing);
        end
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
